//--- design/minx_io_pkg.sv
package minx_io_pkg;

    localparam int NUM_TIMERS = 4;
    localparam int PRESC_W    = 7;      // Prescale counter for exponents 0..7

    typedef logic [7:0]            byte_t;
    typedef logic [23:0]           bus_addr_t;
    typedef logic [7:0]            reg_addr_t;
    typedef logic [PRESC_W-1:0]    presc_t;

    // One event pulse per timer channel
    typedef logic [NUM_TIMERS-1:0] irq_vec_t;

    localparam bus_addr_t IO_BASE = 24'h002000;

    // Interrupt controller registers
    localparam reg_addr_t IRQ_ENABLE_OFS  = 8'h20;
    localparam reg_addr_t IRQ_PENDING_OFS = 8'h21;
    localparam reg_addr_t IRQ_VECTOR_OFS  = 8'h22;

    // Timer block of 4 bytes per channel
    localparam reg_addr_t TIMER_BASE     = 8'h30;
    localparam reg_addr_t TIMER_STRIDE   = 8'h04;
    localparam reg_addr_t TMR_CTRL_OFS   = 8'h00;
    localparam reg_addr_t TMR_RELOAD_OFS = 8'h01;
    localparam reg_addr_t TMR_COUNT_OFS  = 8'h02;

    localparam byte_t VECTOR_BASE = 8'h40;
    localparam byte_t VECTOR_IDLE = 8'h00;

    // Internal register bus request broadcast to every block
    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_addr_t addr;
        byte_t     wdata;
    } reg_req_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        COUNT
    } timer_state_t;

endpackage

//--- design/io_bridge.sv
`timescale 1ns/1ps

module io_bridge
    import minx_io_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Wishbone classic slave
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  bus_addr_t adr,
    input  byte_t     dat_w,
    output logic      ack,
    output byte_t     dat_r,

    // Register bus
    output reg_req_t  reg_req,
    input  byte_t     tmr_rdata [NUM_TIMERS],
    input  byte_t     irq_rdata
);

    logic  req_accept;
    logic  in_window;
    byte_t rdata_or;

    // New request only while ack is low, so two accesses never merge
    assign req_accept = cyc && stb && !ack;

    // Window is IO_BASE..IO_BASE+0xFF, so only the upper address bits matter
    assign in_window = (adr[23:8] == IO_BASE[23:8]);

    // One-cycle strobe in the accepting cycle
    always_comb
    begin
        reg_req.wr    = req_accept && we && in_window;
        reg_req.rd    = req_accept && !we && in_window;
        reg_req.addr  = adr[7:0];
        reg_req.wdata = dat_w;
    end

    // Blocks return zero unless addressed
    always_comb
    begin
        rdata_or = irq_rdata;
        for (int i = 0; i < NUM_TIMERS; i++)
        begin
            rdata_or = rdata_or | tmr_rdata[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= req_accept;          // Exactly one cycle per request
        end
    end

    // Captured on the edge that raises ack
    always_ff @(posedge clk)
    begin
        if (req_accept)
        begin
            if (reg_req.rd)
            begin
                dat_r <= rdata_or;
            end
            else
            begin
                dat_r <= '0;            // Writes and misses read as zero
            end
        end
    end

endmodule

//--- design/timer_channel.sv
`timescale 1ns/1ps

module timer_channel
    import minx_io_pkg::*;
#(
    parameter int CHANNEL = 0
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_req_t reg_req,
    output byte_t    rdata,
    output logic     event_pulse
);

    localparam reg_addr_t BASE = reg_addr_t'(TIMER_BASE + TIMER_STRIDE * CHANNEL);

    byte_t        ctrl_q;
    byte_t        reload_q;
    byte_t        count_q;
    presc_t       presc_q;
    presc_t       presc_mask;
    timer_state_t state_q;
    logic         enable;
    logic         tick;

    assign enable = ctrl_q[0];

    // 2^p - 1 for prescale exponent p in ctrl[3:1]
    assign presc_mask = ~(presc_t'('1) << ctrl_q[3:1]);
    assign tick       = (state_q == COUNT) && ((presc_q & presc_mask) == presc_mask);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctrl_q <= '0;
        end
        else if (reg_req.wr && (reg_req.addr == BASE + TMR_CTRL_OFS))
        begin
            ctrl_q <= reg_req.wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reg_req.wr && (reg_req.addr == BASE + TMR_RELOAD_OFS))
        begin
            reload_q <= reg_req.wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q     <= IDLE;
            count_q     <= '0;
            presc_q     <= '0;
            event_pulse <= 1'b0;
        end
        else
        begin
            event_pulse <= 1'b0;
            case (state_q)
                IDLE:
                begin
                    // Count is frozen here while disabled
                    if (enable)
                    begin
                        count_q <= reload_q;
                        state_q <= LOAD;
                    end
                end
                LOAD:
                begin
                    presc_q <= '0;
                    state_q <= enable ? COUNT : IDLE;
                end
                COUNT:
                begin
                    if (!enable)
                    begin
                        state_q <= IDLE;
                    end
                    else if (tick)
                    begin
                        presc_q <= '0;
                        if (count_q == 8'd0)
                        begin
                            count_q     <= reload_q;    // Underflow
                            event_pulse <= 1'b1;
                        end
                        else
                        begin
                            count_q <= count_q - 8'd1;
                        end
                    end
                    else
                    begin
                        presc_q <= presc_q + presc_t'(1);
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_comb
    begin
        case (reg_req.addr)
            BASE + TMR_CTRL_OFS:   rdata = ctrl_q;
            BASE + TMR_RELOAD_OFS: rdata = reload_q;
            BASE + TMR_COUNT_OFS:  rdata = count_q;    // Live count is read only
            default:               rdata = '0;
        endcase
    end

endmodule

//--- design/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl
    import minx_io_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_req_t reg_req,
    input  irq_vec_t tmr_irq,
    output byte_t    rdata,
    output logic     irq,
    output byte_t    vector
);

    irq_vec_t enable_q;
    irq_vec_t pending_q;
    irq_vec_t pending_clr;
    irq_vec_t active;
    logic     enable_wr;
    logic     pending_wr;

    assign enable_wr  = reg_req.wr && (reg_req.addr == IRQ_ENABLE_OFS);
    assign pending_wr = reg_req.wr && (reg_req.addr == IRQ_PENDING_OFS);

    // Write 1 to clear
    assign pending_clr = pending_wr ? reg_req.wdata[NUM_TIMERS-1:0] : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            enable_q <= '0;
        end
        else if (enable_wr)
        begin
            enable_q <= reg_req.wdata[NUM_TIMERS-1:0];
        end
    end

    // Events latch regardless of enable
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pending_q <= '0;
        end
        else
        begin
            pending_q <= (pending_q & ~pending_clr) | tmr_irq;  // Set beats clear
        end
    end

    assign active = pending_q & enable_q;
    assign irq    = |active;

    // Channel 0 has the highest priority
    always_comb
    begin
        vector = VECTOR_IDLE;
        for (int i = NUM_TIMERS - 1; i >= 0; i--)
        begin
            if (active[i])
            begin
                vector = VECTOR_BASE + byte_t'(i);
            end
        end
    end

    always_comb
    begin
        case (reg_req.addr)
            IRQ_ENABLE_OFS:  rdata = byte_t'(enable_q);
            IRQ_PENDING_OFS: rdata = byte_t'(pending_q);
            IRQ_VECTOR_OFS:  rdata = vector;
            default:         rdata = '0;
        endcase
    end

endmodule

//--- design/minx_io.sv
`timescale 1ns/1ps

module minx_io
    import minx_io_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  bus_addr_t adr,
    input  byte_t     dat_w,
    output logic      ack,
    output byte_t     dat_r,
    output logic      irq,
    output byte_t     vector
);

    reg_req_t reg_req;
    byte_t    tmr_rdata [NUM_TIMERS];
    byte_t    irq_rdata;
    irq_vec_t tmr_irq;

    io_bridge u_bridge
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .ack       (ack),
        .dat_r     (dat_r),
        .reg_req   (reg_req),
        .tmr_rdata (tmr_rdata),
        .irq_rdata (irq_rdata)
    );

    // Channel n decodes TIMER_BASE + 4n
    for (genvar g = 0; g < NUM_TIMERS; g++)
    begin : gen_timer
        timer_channel #(.CHANNEL(g)) u_timer
        (
            .clk         (clk),
            .rst_n       (rst_n),
            .reg_req     (reg_req),
            .rdata       (tmr_rdata[g]),
            .event_pulse (tmr_irq[g])
        );
    end

    irq_ctrl u_irq
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .reg_req (reg_req),
        .tmr_irq (tmr_irq),
        .rdata   (irq_rdata),
        .irq     (irq),
        .vector  (vector)
    );

endmodule

//--- tests/minx_io_tb.sv
`timescale 1ns/1ps

module minx_io_tb
    import minx_io_pkg::*;
();

    localparam string STIM_FILE     = "tests/minx_io_stim.txt";
    localparam int    RESET_CYCLES  = 10;
    localparam int    CYCLES_PER_OP = 64;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      cyc;
    logic      stb;
    logic      we;
    bus_addr_t adr;
    byte_t     dat_w;
    logic      ack;
    byte_t     dat_r;
    logic      irq;
    byte_t     vector;

    int cycle_count = 0;
    int cycle_limit = 0;    // Set once the stim file is scanned

    minx_io UUT
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .ack    (ack),
        .dat_r  (dat_r),
        .irq    (irq),
        .vector (vector)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic open_stim(output int fd);
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("The stimulus file %s could not be opened", STIM_FILE);
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing stimulus file");
        end
    endtask

    task automatic reject_op(input logic [63:0] op);
        $display("Unknown operation '%0s' in the stimulus file", op);
        $display("TEST RESULT: FAIL");
        $fatal(1, "bad stimulus");
    endtask

    // First pass only sizes the timeout
    task automatic scan_stim(output int num_ops, output int wait_sum);
        int               fd;
        int               code;
        int               n;
        logic [63:0]      op;
        logic [8*256-1:0] line;
        num_ops  = 0;
        wait_sum = 0;
        open_stim(fd);
        code = $fscanf(fd, "%s", op);
        while (code == 1)
        begin
            if (op == "D")
            begin
                code     = $fscanf(fd, "%d", n);
                wait_sum = wait_sum + n;
                num_ops  = num_ops + 1;
            end
            else
            begin
                code = $fgets(line, fd);
                if (op != "#")
                begin
                    num_ops = num_ops + 1;
                end
            end
            code = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
    endtask

    // Starts 1 ns after an edge, returns 1 ns after the edge that raised ack
    task automatic wb_access(input logic write, input bus_addr_t addr, input byte_t wdata,
                             output byte_t rdata);
        @(posedge clk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        do
        begin
            @(posedge clk);
            #1;
        end while (ack !== 1'b1);
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_pins(input logic exp_irq, input byte_t exp_vec);
        @(posedge clk);
        #1;
        check_value(32'(irq), 32'(exp_irq), "irq pin");
        check_value(32'(vector), 32'(exp_vec), "vector pin");
    endtask

    task automatic run_stim();
        int               fd;
        int               code;
        int               n;
        logic [63:0]      op;
        logic [8*256-1:0] line;
        bus_addr_t        addr;
        byte_t            data;
        byte_t            rd;
        logic             exp_irq;
        byte_t            exp_vec;
        open_stim(fd);
        code = $fscanf(fd, "%s", op);
        while (code == 1)
        begin
            if (op == "#")
            begin
                code = $fgets(line, fd);   // Comment line
            end
            else if (op == "W")
            begin
                code = $fscanf(fd, "%h %h", addr, data);
                wb_access(1'b1, addr, data, rd);
            end
            else if (op == "R")
            begin
                code = $fscanf(fd, "%h %h", addr, data);
                wb_access(1'b0, addr, 8'h00, rd);
                check_value(32'(rd), 32'(data), $sformatf("read of address %06h", addr));
            end
            else if (op == "D")
            begin
                code = $fscanf(fd, "%d", n);
                wait_cycles(n);
            end
            else if (op == "I")
            begin
                code = $fscanf(fd, "%h %h", exp_irq, exp_vec);
                check_pins(exp_irq, exp_vec);
            end
            else
            begin
                reject_op(op);
            end
            code = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
    endtask

    initial
    begin
        int num_ops;
        int wait_sum;
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        scan_stim(num_ops, wait_sum);
        cycle_limit = RESET_CYCLES + CYCLES_PER_OP * num_ops + wait_sum;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_stim();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- list.f
design/minx_io_pkg.sv
design/io_bridge.sv
design/timer_channel.sv
design/irq_ctrl.sv
design/minx_io.sv
tests/minx_io_tb.sv

//--- Makefile
# Verilator build and run for the minx_io register space

VERILATOR ?= verilator
TOP       ?= minx_io_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST RESULT: PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is decided by the pass message in the simulation output
run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/minx_io_stim.txt
# Ops: W addr data | R addr expected | I irq vector | D cycles
# Addresses and data in hex, D cycles in decimal
R 002021 00
R 002022 00
I 0 00
W 002020 0F
R 002020 0F
W 002020 00
W 002031 03
R 002031 03
W 002035 02
R 002035 02
W 002039 50
R 002039 50
W 00203D 04
R 00203D 04
W 002030 0E
R 002030 0E
W 002034 06
R 002034 06
W 002038 0C
R 002038 0C
W 00203C F0
R 00203C F0
# Outside the window
W 012035 FF
R 012035 00
R 002035 02
W 001F20 FF
R 002020 00
# Channel 0 period is 8 clocks
W 002030 03
D 16
R 002021 01
W 002030 00
W 002021 01
R 002021 00
# Channels 1 and 3 for masking and priority
W 002034 01
W 00203C 03
D 30
R 002021 0A
I 0 00
W 002020 08
I 1 43
W 002020 0A
I 1 41
W 002034 00
W 00203C 00
W 002021 02
R 002021 08
I 1 43
# Channel 2 at prescale 128, one decrement before the stop
W 002038 0F
D 200
W 002038 00
R 00203A 4F
D 300
R 00203A 4F
